// File: source/decode_pkg.sv
package decode_pkg;

	localparam int m_width = 64; // pc, immediate and target width
	localparam int lg_prf_entries = 6;
	localparam int lg_pht_sz = 8;

	// ordinals are fixed, the vector file depends on them
	typedef enum logic [6:0]
	{
		II,
		NOP,
		LB,
		LH,
		LW,
		LD,
		LBU,
		LHU,
		ADDI,
		SLLI,
		SLTI,
		SLTIU,
		XORI,
		SRLI,
		SRAI,
		ORI,
		ANDI,
		AUIPC,
		ADDIW,
		SLLIW,
		SRAIW,
		SB,
		SH,
		SW,
		SD,
		ADDU,
		SUBU,
		MUL,
		SLL,
		MULH,
		SLT,
		SLTU,
		MULHU,
		XOR,
		DIV,
		SRL,
		DIVU,
		SRA,
		OR,
		REM,
		AND,
		REMU,
		LUI,
		ADDW,
		SUBW,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU,
		JALR,
		JR,
		RET,
		J,
		JAL,
		BREAK,
		MONITOR,
		RDCYCLE,
		RDCYCLEH,
		RDINSTRET,
		RDINSTRETH,
		RDBRANCH,
		RDFAULTEDBRANCH
	} uop_op_e;

endpackage

// File: source/pc_imm_gen.sv
`timescale 1ns/1ps

module pc_imm_gen
(
	input logic [31:0] insn,
	input logic [decode_pkg::m_width-1:0] pc,
	input logic mode64,
	output logic [decode_pkg::m_width-1:0] pc_imm
);
	import decode_pkg::*;

	logic [m_width-1:0] sel_imm;
	logic [m_width-1:0] sum;

	always_comb
	begin
		sel_imm = '0;
		case (insn[6:0])
			7'h17: // auipc
			begin
				sel_imm = {{(m_width-32){insn[31]}}, insn[31:12], 12'd0};
			end
			7'h63: // conditional branches
			begin
				sel_imm = {{(m_width-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
			end
			7'h6f: // jal
			begin
				sel_imm = {{(m_width-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
			end
			default:
			begin
				sel_imm = '0;
			end
		endcase
	end

	assign sum = pc + sel_imm;

	// rv32 target wraps at 32 bits
	assign pc_imm = mode64 ? sum : {{(m_width-32){sum[31]}}, sum[31:0]};

endmodule

// File: source/decode_riscv.sv
`timescale 1ns/1ps

module decode_riscv
(
	input logic mode64,
	input logic [31:0] insn,
	input logic [decode_pkg::m_width-1:0] pc,
	input logic insn_pred,
	input logic [decode_pkg::lg_pht_sz-1:0] pht_idx,
	input logic [decode_pkg::m_width-1:0] insn_pred_target,
	output decode_pkg::uop_op_e op,
	output logic [decode_pkg::lg_prf_entries-1:0] src_a,
	output logic [decode_pkg::lg_prf_entries-1:0] src_b,
	output logic [decode_pkg::lg_prf_entries-1:0] dst,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic [decode_pkg::m_width-17:0] jmp_imm,
	output logic [decode_pkg::m_width-1:0] rvimm,
	output logic is_mem,
	output logic is_store,
	output logic is_int,
	output logic is_cheap_int,
	output logic is_br,
	output logic br_pred,
	output logic serializing_op,
	output logic must_restart,
	output logic [decode_pkg::m_width-1:0] uop_pc,
	output logic [decode_pkg::lg_pht_sz-1:0] uop_pht_idx
);
	import decode_pkg::*;

	wire [6:0] opcode = insn[6:0];
	wire [2:0] funct3 = insn[14:12];
	wire [6:0] funct7 = insn[31:25];

	wire [lg_prf_entries-1:0] rd = {{(lg_prf_entries-5){1'b0}}, insn[11:7]};
	wire [lg_prf_entries-1:0] rs1 = {{(lg_prf_entries-5){1'b0}}, insn[19:15]};
	wire [lg_prf_entries-1:0] rs2 = {{(lg_prf_entries-5){1'b0}}, insn[24:20]};
	wire rs1_is_link = (rs1 == 'd1) || (rs1 == 'd5); // ra or t0

	wire [m_width-1:0] i_imm = {{(m_width-12){insn[31]}}, insn[31:20]};
	wire [m_width-1:0] s_imm = {{(m_width-12){insn[31]}}, insn[31:25], insn[11:7]};
	wire [m_width-1:0] u_imm = {{(m_width-32){insn[31]}}, insn[31:12], 12'd0};

	logic [m_width-1:0] pc_imm;
	logic fold_x0; // op becomes NOP when rd is x0

	pc_imm_gen u_pc_imm_gen
	(
		.insn(insn),
		.pc(pc),
		.mode64(mode64),
		.pc_imm(pc_imm)
	);

	assign uop_pc = pc;
	assign uop_pht_idx = pht_idx;

	always_comb
	begin
		op = II;
		src_a = '0;
		src_b = '0;
		dst = '0;
		src_a_valid = 1'b0;
		src_b_valid = 1'b0;
		dst_valid = 1'b0;
		imm = 16'd0;
		jmp_imm = '0;
		rvimm = '0;
		is_mem = 1'b0;
		is_store = 1'b0;
		is_int = 1'b0;
		is_cheap_int = 1'b0;
		is_br = 1'b0;
		br_pred = 1'b0;
		serializing_op = 1'b0;
		must_restart = 1'b0;
		fold_x0 = 1'b0;
		case (opcode)
			7'h03: // loads
			begin
				dst = rd;
				src_a = rs1;
				dst_valid = (rd != '0);
				src_a_valid = 1'b1;
				is_mem = 1'b1;
				rvimm = i_imm;
				case (funct3)
					3'd0: op = LB;
					3'd1: op = LH;
					3'd2: op = LW;
					3'd3: op = LD;
					3'd4: op = LBU;
					3'd5: op = LHU;
					default: op = II;
				endcase
			end
			7'h0f: op = NOP; // fence
			7'h13:
			begin
				dst = rd;
				src_a = rs1;
				dst_valid = (rd != '0);
				src_a_valid = (rd != '0);
				is_int = 1'b1;
				rvimm = i_imm;
				fold_x0 = 1'b1;
				case (funct3)
					3'd0: op = ADDI;
					3'd1: op = SLLI;
					3'd2: op = SLTI;
					3'd3: op = SLTIU;
					3'd4: op = XORI;
					3'd5:
						if (insn[31:26] == 6'h00)
							op = SRLI;
						else if (insn[31:26] == 6'h10)
							op = SRAI;
					3'd6: op = ORI;
					3'd7: op = ANDI;
					default: op = II;
				endcase
				is_cheap_int = (op != II);
			end
			7'h17: // auipc
			begin
				op = AUIPC;
				dst = rd;
				dst_valid = (rd != '0);
				is_int = 1'b1;
				is_cheap_int = 1'b1;
				rvimm = pc_imm;
				fold_x0 = 1'b1;
			end
			7'h1b: // word immediates
			begin
				dst = rd;
				src_a = rs1;
				dst_valid = (rd != '0);
				src_a_valid = (rd != '0);
				is_int = 1'b1;
				rvimm = i_imm;
				fold_x0 = 1'b1;
				case (funct3)
					3'd0: op = ADDIW;
					3'd1: op = SLLIW;
					3'd5: op = SRAIW;
					default: op = II;
				endcase
				is_cheap_int = (op != II);
			end
			7'h23: // stores
			begin
				src_a = rs1;
				src_b = rs2;
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				is_mem = 1'b1;
				is_store = 1'b1;
				rvimm = s_imm;
				case (funct3)
					3'd0: op = SB;
					3'd1: op = SH;
					3'd2: op = SW;
					3'd3: op = SD;
					default: op = II;
				endcase
			end
			7'h33:
			begin
				dst = rd;
				src_a = rs1;
				src_b = rs2;
				dst_valid = (rd != '0);
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				is_int = 1'b1;
				fold_x0 = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'd0}: op = ADDU;
					{7'h01, 3'd0}: op = MUL;
					{7'h20, 3'd0}: op = SUBU;
					{7'h00, 3'd1}: op = SLL;
					{7'h01, 3'd1}: op = MULH;
					{7'h00, 3'd2}: op = SLT;
					{7'h00, 3'd3}: op = SLTU;
					{7'h01, 3'd3}: op = MULHU;
					{7'h00, 3'd4}: op = XOR;
					{7'h01, 3'd4}: op = DIV;
					{7'h00, 3'd5}: op = SRL;
					{7'h01, 3'd5}: op = DIVU;
					{7'h20, 3'd5}: op = SRA;
					{7'h00, 3'd6}: op = OR;
					{7'h01, 3'd6}: op = REM;
					{7'h00, 3'd7}: op = AND;
					{7'h01, 3'd7}: op = REMU;
					default: op = II;
				endcase
				is_cheap_int = (op != II) && (funct7 != 7'h01); // muldiv is not cheap
			end
			7'h37: // lui
			begin
				op = LUI;
				dst = rd;
				dst_valid = (rd != '0);
				is_int = 1'b1;
				is_cheap_int = 1'b1;
				rvimm = u_imm;
				fold_x0 = 1'b1;
			end
			7'h3b:
			begin
				dst = rd;
				src_a = rs1;
				src_b = rs2;
				dst_valid = (rd != '0);
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				is_int = 1'b1;
				fold_x0 = 1'b1;
				if (funct3 == 3'd0 && funct7 == 7'h00)
					op = ADDW;
				else if (funct3 == 3'd0 && funct7 == 7'h20)
					op = SUBW;
				is_cheap_int = (op != II);
			end
			7'h63: // conditional branches
			begin
				src_a = rs1;
				src_b = rs2;
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				is_int = 1'b1;
				is_cheap_int = 1'b1;
				is_br = 1'b1;
				br_pred = insn_pred;
				rvimm = pc_imm;
				case (funct3)
					3'd0: op = BEQ;
					3'd1: op = BNE;
					3'd4: op = BLT;
					3'd5: op = BGE;
					3'd6: op = BLTU;
					3'd7: op = BGEU;
					default: op = II;
				endcase
			end
			7'h67: // jalr, jr, ret
			begin
				src_a = rs1;
				src_a_valid = 1'b1;
				is_int = 1'b1;
				is_cheap_int = 1'b1;
				is_br = 1'b1;
				br_pred = 1'b1;
				imm = insn_pred_target[15:0];
				jmp_imm = insn_pred_target[m_width-1:16];
				rvimm = i_imm;
				if (rd == '0)
					op = rs1_is_link ? RET : JR;
				else
				begin
					op = JALR;
					dst = rd;
					dst_valid = 1'b1;
				end
			end
			7'h6f: // jal, j
			begin
				is_int = 1'b1;
				is_br = 1'b1;
				br_pred = 1'b1;
				rvimm = pc_imm;
				if (rd == '0)
					op = J;
				else
				begin
					op = JAL;
					dst = rd;
					dst_valid = 1'b1;
					is_cheap_int = 1'b1;
				end
			end
			7'h73: // system
			begin
				is_int = 1'b1;
				op = NOP;
				if (insn[31:7] == '0)
				begin
					op = BREAK;
					serializing_op = 1'b1;
				end
				else if (insn[31:20] == 12'd1 && insn[19:7] == '0)
				begin
					op = MONITOR;
					serializing_op = 1'b1;
					must_restart = 1'b1;
				end
				else if (funct3 == 3'd2) // csrrs counter reads
				begin
					case (insn[31:20])
						12'hc00: op = RDCYCLE;
						12'hc02: op = RDINSTRET;
						12'hc03: op = RDBRANCH;
						12'hc80:
							if (!mode64)
								op = RDCYCLEH;
						12'hc82:
							if (!mode64)
								op = RDINSTRETH;
						12'hc04: op = RDFAULTEDBRANCH;
						default: op = NOP;
					endcase
					if (op != NOP)
					begin
						dst = rd;
						dst_valid = (rd != '0);
						serializing_op = 1'b1;
						fold_x0 = 1'b1;
					end
				end
			end
			default: op = II;
		endcase
		if (fold_x0 && rd == '0 && op != II)
			op = NOP;
	end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
	input logic clk,
	input logic reset,
	input logic insn_valid,
	input logic mode64,
	input logic [31:0] insn,
	input logic [decode_pkg::m_width-1:0] pc,
	input logic insn_pred,
	input logic [decode_pkg::lg_pht_sz-1:0] pht_idx,
	input logic [decode_pkg::m_width-1:0] insn_pred_target,
	output logic uop_valid,
	output decode_pkg::uop_op_e op,
	output logic [decode_pkg::lg_prf_entries-1:0] src_a,
	output logic [decode_pkg::lg_prf_entries-1:0] src_b,
	output logic [decode_pkg::lg_prf_entries-1:0] dst,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic [decode_pkg::m_width-17:0] jmp_imm,
	output logic [decode_pkg::m_width-1:0] rvimm,
	output logic is_mem,
	output logic is_store,
	output logic is_int,
	output logic is_cheap_int,
	output logic is_br,
	output logic br_pred,
	output logic serializing_op,
	output logic must_restart,
	output logic [decode_pkg::m_width-1:0] uop_pc,
	output logic [decode_pkg::lg_pht_sz-1:0] uop_pht_idx
);
	import decode_pkg::*;

	uop_op_e d_op;
	logic [lg_prf_entries-1:0] d_src_a, d_src_b, d_dst;
	logic d_src_a_valid, d_src_b_valid, d_dst_valid;
	logic [15:0] d_imm;
	logic [m_width-17:0] d_jmp_imm;
	logic [m_width-1:0] d_rvimm, d_pc;
	logic d_is_mem, d_is_store, d_is_int, d_is_cheap_int;
	logic d_is_br, d_br_pred, d_serializing_op, d_must_restart;
	logic [lg_pht_sz-1:0] d_pht_idx;

	decode_riscv u_decode
	(
		.mode64(mode64),
		.insn(insn),
		.pc(pc),
		.insn_pred(insn_pred),
		.pht_idx(pht_idx),
		.insn_pred_target(insn_pred_target),
		.op(d_op),
		.src_a(d_src_a),
		.src_b(d_src_b),
		.dst(d_dst),
		.src_a_valid(d_src_a_valid),
		.src_b_valid(d_src_b_valid),
		.dst_valid(d_dst_valid),
		.imm(d_imm),
		.jmp_imm(d_jmp_imm),
		.rvimm(d_rvimm),
		.is_mem(d_is_mem),
		.is_store(d_is_store),
		.is_int(d_is_int),
		.is_cheap_int(d_is_cheap_int),
		.is_br(d_is_br),
		.br_pred(d_br_pred),
		.serializing_op(d_serializing_op),
		.must_restart(d_must_restart),
		.uop_pc(d_pc),
		.uop_pht_idx(d_pht_idx)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			uop_valid <= 1'b0;
			op <= II;
			src_a <= '0;
			src_b <= '0;
			dst <= '0;
			src_a_valid <= 1'b0;
			src_b_valid <= 1'b0;
			dst_valid <= 1'b0;
			imm <= '0;
			jmp_imm <= '0;
			rvimm <= '0;
			is_mem <= 1'b0;
			is_store <= 1'b0;
			is_int <= 1'b0;
			is_cheap_int <= 1'b0;
			is_br <= 1'b0;
			br_pred <= 1'b0;
			serializing_op <= 1'b0;
			must_restart <= 1'b0;
			uop_pc <= '0;
			uop_pht_idx <= '0;
		end
		else if (insn_valid)
		begin
			uop_valid <= 1'b1;
			op <= d_op;
			src_a <= d_src_a;
			src_b <= d_src_b;
			dst <= d_dst;
			src_a_valid <= d_src_a_valid;
			src_b_valid <= d_src_b_valid;
			dst_valid <= d_dst_valid;
			imm <= d_imm;
			jmp_imm <= d_jmp_imm;
			rvimm <= d_rvimm;
			is_mem <= d_is_mem;
			is_store <= d_is_store;
			is_int <= d_is_int;
			is_cheap_int <= d_is_cheap_int;
			is_br <= d_is_br;
			br_pred <= d_br_pred;
			serializing_op <= d_serializing_op;
			must_restart <= d_must_restart;
			uop_pc <= d_pc;
			uop_pht_idx <= d_pht_idx;
		end
		else
			uop_valid <= 1'b0; // payload holds
	end

	// a store must also go down the memory pipe
	a_store_is_mem: assert property (@(posedge clk) disable iff (reset)
		uop_valid |-> (!is_store || is_mem));

	// only links may target a register picked up without the x0 check
	a_dst_nonzero: assert property (@(posedge clk) disable iff (reset)
		(uop_valid && dst_valid) |-> (dst != '0 || op == JAL || op == JALR));

	a_idle_after_reset: assert property (@(posedge clk)
		reset |=> !uop_valid);

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic reset
);
	localparam int half_period = 2; // 4 ns clock

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge clk);
		@(negedge clk); // release away from the sampling edge
		reset = 1'b0;
	end

endmodule

// File: sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
	import decode_pkg::*;

	localparam string vector_file = "sim/decode_input.txt";

	typedef struct packed
	{
		logic gap;
		logic [31:0] insn;
		logic [63:0] pc;
		logic mode64;
		logic pred;
		logic [7:0] pht;
		logic [63:0] target;
		logic [6:0] op;
		logic [5:0] dst;
		logic dst_valid;
		logic [5:0] src_a;
		logic src_a_valid;
		logic [5:0] src_b;
		logic src_b_valid;
		logic [63:0] rvimm;
		logic [7:0] flags;
	} vector_t;

	logic clk;
	logic reset;
	logic insn_valid;
	logic mode64;
	logic [31:0] insn;
	logic [m_width-1:0] pc;
	logic insn_pred;
	logic [lg_pht_sz-1:0] pht_idx;
	logic [m_width-1:0] insn_pred_target;
	logic uop_valid;
	uop_op_e op;
	logic [lg_prf_entries-1:0] src_a;
	logic [lg_prf_entries-1:0] src_b;
	logic [lg_prf_entries-1:0] dst;
	logic src_a_valid;
	logic src_b_valid;
	logic dst_valid;
	logic [15:0] imm;
	logic [m_width-17:0] jmp_imm;
	logic [m_width-1:0] rvimm;
	logic is_mem;
	logic is_store;
	logic is_int;
	logic is_cheap_int;
	logic is_br;
	logic br_pred;
	logic serializing_op;
	logic must_restart;
	logic [m_width-1:0] uop_pc;
	logic [lg_pht_sz-1:0] uop_pht_idx;

	vector_t vectors[$];
	string names[$];
	int mismatch_count = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 50;
	int unsigned lcg_state = 74;
	bit has_last = 1'b0; // a vector was already latched
	int last_idx = 0;

	tb_clock_gen u_clock_gen
	(
		.clk(clk),
		.reset(reset)
	);

	decode_stage dut (.*);

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string test, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			mismatch_count++;
			$display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
		end
	endtask

	task automatic load_vectors();
		int fd;
		int count;
		string line;
		string word;
		logic gap_pending;
		vector_t v;
		logic [63:0] col [0:14];
		gap_pending = 1'b0;
		fd = $fopen(vector_file, "r");
		if (fd == 0)
		begin
			other_errors++;
			$display("ERROR: cannot open %s", vector_file);
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			count = $sscanf(line, "%s", word);
			if (count != 1 || word.getc(0) == "#")
				continue;
			if (word == "gap")
			begin
				gap_pending = 1'b1;
				continue;
			end
			count = $sscanf(line, "%s %h %h %h %h %h %h %d %d %d %d %d %d %d %h %h", word,
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
			if (count != 16)
			begin
				other_errors++;
				$display("ERROR: vector line for %s has missing columns", word);
				continue;
			end
			v.gap = gap_pending;
			v.insn = col[0][31:0];
			v.pc = col[1];
			v.mode64 = col[2][0];
			v.pred = col[3][0];
			v.pht = col[4][7:0];
			v.target = col[5];
			v.op = col[6][6:0];
			v.dst = col[7][5:0];
			v.dst_valid = col[8][0];
			v.src_a = col[9][5:0];
			v.src_a_valid = col[10][0];
			v.src_b = col[11][5:0];
			v.src_b_valid = col[12][0];
			v.rvimm = col[13];
			v.flags = col[14][7:0];
			vectors.push_back(v);
			names.push_back(word);
			gap_pending = 1'b0;
		end
		$fclose(fd);
		if (vectors.size() == 0)
		begin
			other_errors++;
			$display("ERROR: no vectors were loaded from %s", vector_file);
		end
	endtask

	task automatic drive_vector(input int i);
		insn = vectors[i].insn;
		pc = vectors[i].pc;
		mode64 = vectors[i].mode64;
		insn_pred = vectors[i].pred;
		pht_idx = vectors[i].pht;
		insn_pred_target = vectors[i].target;
		insn_valid = 1'b1;
	endtask

	// outputs still show the previous cycle until the next rising edge
	task automatic check_latency(input int i);
		logic prev_valid;
		logic [63:0] prev_op;
		logic [63:0] prev_rvimm;
		prev_valid = has_last && !vectors[i].gap;
		prev_op = '0;
		prev_rvimm = '0;
		if (has_last)
		begin
			prev_op = 64'(vectors[last_idx].op);
			prev_rvimm = vectors[last_idx].rvimm;
		end
		assert (uop_valid === prev_valid)
		else
		begin
			other_errors++;
			$display("ERROR: uop_valid changed before the clock edge for %s", names[i]);
		end
		check_value(names[i], "op before edge", prev_op, 64'(op));
		check_value(names[i], "rvimm before edge", prev_rvimm, rvimm);
	endtask

	task automatic check_vector(input int i);
		vector_t v;
		logic [15:0] exp_imm;
		logic [m_width-17:0] exp_jmp_imm;
		v = vectors[i];
		exp_imm = '0;
		exp_jmp_imm = '0;
		if (v.op == JALR || v.op == JR || v.op == RET)
		begin
			exp_imm = v.target[15:0]; // predicted target split in two
			exp_jmp_imm = v.target[63:16];
		end
		assert (uop_valid === 1'b1)
		else
		begin
			other_errors++;
			$display("ERROR: %s was strobed but uop_valid stayed low", names[i]);
		end
		check_value(names[i], "op", 64'(v.op), 64'(op));
		check_value(names[i], "dst", 64'(v.dst), 64'(dst));
		check_value(names[i], "dst_valid", 64'(v.dst_valid), 64'(dst_valid));
		check_value(names[i], "src_a", 64'(v.src_a), 64'(src_a));
		check_value(names[i], "src_a_valid", 64'(v.src_a_valid), 64'(src_a_valid));
		check_value(names[i], "src_b", 64'(v.src_b), 64'(src_b));
		check_value(names[i], "src_b_valid", 64'(v.src_b_valid), 64'(src_b_valid));
		check_value(names[i], "rvimm", v.rvimm, rvimm);
		check_value(names[i], "flags", 64'(v.flags), 64'({is_mem, is_store, is_int,
			is_cheap_int, is_br, br_pred, serializing_op, must_restart}));
		check_value(names[i], "imm", 64'(exp_imm), 64'(imm));
		check_value(names[i], "jmp_imm", 64'(exp_jmp_imm), 64'(jmp_imm));
		check_value(names[i], "uop_pc", v.pc, uop_pc);
		check_value(names[i], "uop_pht_idx", 64'(v.pht), 64'(uop_pht_idx));
	endtask

	task automatic check_idle();
		logic [63:0] held_op;
		logic [63:0] held_rvimm;
		held_op = '0; // zero straight out of reset
		held_rvimm = '0;
		if (has_last)
		begin
			held_op = 64'(vectors[last_idx].op);
			held_rvimm = vectors[last_idx].rvimm;
		end
		assert (uop_valid === 1'b0)
		else
		begin
			other_errors++;
			$display("ERROR: uop_valid is high in an idle cycle at %0t", $time);
		end
		check_value("idle", "op", held_op, 64'(op));
		check_value("idle", "rvimm", held_rvimm, rvimm);
	endtask

	task automatic insert_gap();
		int gap_cycles;
		lcg_state = lcg_next(lcg_state);
		gap_cycles = 1 + int'((lcg_state >> 16) % 4);
		insn_valid = 1'b0;
		repeat (gap_cycles)
		begin
			@(negedge clk);
			check_idle();
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("ERROR: run did not finish within %0d cycles", cycle_limit);
			$display("summary: %0d mismatches, %0d other errors", mismatch_count,
				other_errors + 1);
			$display("tests failed");
			$finish;
		end
	end

	initial
	begin
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		mode64 = 1'b1;
		insn_pred = 1'b0;
		pht_idx = '0;
		insn_pred_target = '0;
		load_vectors();
		cycle_limit = 8 * vectors.size() + 50;
		@(posedge clk);
		while (reset)
			@(posedge clk);
		@(negedge clk);
		check_idle(); // outputs cleared by reset
		for (int i = 0; i < vectors.size(); i++)
		begin
			if (vectors[i].gap)
				insert_gap();
			drive_vector(i);
			#1; // middle of the low phase
			check_latency(i);
			@(negedge clk);
			check_vector(i);
			has_last = 1'b1;
			last_idx = i;
		end
		insn_valid = 1'b0;
		@(negedge clk);
		check_idle();
		$display("summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: sim/decode_input.txt
# name insn pc mode64 insn_pred pht_idx insn_pred_target (hex inputs)
# op dst dst_valid src_a src_a_valid src_b src_b_valid (decimal) rvimm flags (hex)
addi_neg ffd30293 1000 1 0 00 0 8 5 1 6 1 0 0 fffffffffffffffd 30
srai_shift 4045d513 1004 1 0 01 0 14 10 1 11 1 0 0 404 30
sub_reg 403100b3 1008 1 0 02 0 26 1 1 2 1 3 1 0 30
mul_reg 029403b3 100c 1 0 03 0 27 7 1 8 1 9 1 0 20
lui_high 80000637 1010 1 0 04 0 42 12 1 0 0 0 0 ffffffff80000000 30
addiw_one 0017069b 1014 1 0 05 0 18 13 1 14 1 0 0 1 30
addw_reg 011807bb 1018 1 0 06 0 43 15 1 16 1 17 1 0 30
addi_x0_nop 00508013 101c 1 0 07 0 1 0 0 1 0 0 0 5 30
add_x0_nop 00310033 1020 1 0 08 0 1 0 0 2 1 3 1 0 30
gap
ld_pos 01013203 2000 1 0 10 0 5 4 1 2 1 0 0 10 80
lbu_neg fff3c303 2004 1 0 11 0 6 6 1 7 1 0 0 ffffffffffffffff 80
sd_split 02943423 2008 1 0 12 0 24 0 0 8 1 9 1 28 c0
sw_neg fe112e23 200c 1 0 13 0 23 0 0 2 1 1 1 fffffffffffffffc c0
gap
beq_taken 00208863 1000 1 1 20 0 45 0 0 1 1 2 1 1010 3c
bne_back fe419ce3 2000 1 0 21 0 46 0 0 3 1 4 1 1ff8 38
bge_fold32 0262d063 7ffffff0 0 1 22 0 48 0 0 5 1 6 1 ffffffff80000010 3c
auipc_fold32 12345197 80000000 0 0 23 0 17 3 1 0 0 0 0 ffffffff92345000 30
jal_link 001000ef 4000 1 0 24 0 55 1 1 0 0 0 0 4800 3c
j_back ffdff06f 4010 0 0 25 0 54 0 0 0 0 0 0 400c 2c
gap
ret_ra 00008067 3000 1 1 30 0000123456789abc 53 0 0 1 1 0 0 0 3c
jr_reg 00030067 3004 1 0 31 ffff800000000040 52 0 0 6 1 0 0 0 3c
jalr_link 008280e7 3008 1 0 32 0000000080001000 51 1 1 5 1 0 0 8 3c
ret_t0 00028067 300c 1 1 33 2000 53 0 0 5 1 0 0 0 3c
gap
ecall_break 00000073 5000 1 0 40 0 56 0 0 0 0 0 0 0 22
monitor 00100073 5004 1 0 41 0 57 0 0 0 0 0 0 0 23
rdcycle c0002573 5008 1 0 42 0 58 10 1 0 0 0 0 0 22
rdinstret c02025f3 500c 1 0 43 0 60 11 1 0 0 0 0 0 22
rdcycleh_rv32 c8002673 5010 0 0 44 0 59 12 1 0 0 0 0 0 22
rdcycleh_rv64 c8002673 5014 1 0 45 0 1 0 0 0 0 0 0 0 20
rdinstreth_rv32 c82026f3 5018 0 0 46 0 61 13 1 0 0 0 0 0 22
rdbranch c0302773 501c 1 0 47 0 62 14 1 0 0 0 0 0 22
rdcycle_x0_nop c0002073 5020 1 0 48 0 1 0 0 0 0 0 0 0 22
gap
zero_word 00000000 6000 1 0 50 0 0 0 0 0 0 0 0 0 00
bad_funct7 200000b3 6004 1 0 51 0 0 1 1 0 1 0 1 0 20
bad_load 00007183 6008 1 0 52 0 0 3 1 0 1 0 0 0 80
bad_branch 00002063 0100 1 0 53 0 0 0 0 0 1 0 1 100 38

// File: project.f
source/decode_pkg.sv
source/pc_imm_gen.sv
source/decode_riscv.sv
source/decode_stage.sv
sim/tb_clock_gen.sv
sim/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_decode_stage --Mdir "$build_dir" \
	-o vtb_decode_stage -f project.f
then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/vtb_decode_stage" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$log_file"; then
	exit 0
fi

echo "pass line not found in $log_file"
exit 1
